// ==== Makefile ====
# Verilator lint and simulation of the trap unit

TOP := trap_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f list.f

# a simulator abort counts as a failed run in the log
sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== hdl/apb_arbiter.sv ====
/*
 * fixed-priority APB arbiter
 * two requesters (core, debug) onto one completer
 * core wins ties, grant held until the access completes
 */
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module apb_arbiter (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      core_psel,
	input  wire                      core_penable,
	input  wire                      core_pwrite,
	input  wire [`TRAP_CSR_AW-1:0]   core_paddr,
	input  wire [`TRAP_XLEN-1:0]     core_pwdata,
	output logic [`TRAP_XLEN-1:0]    core_prdata,
	output logic                     core_pready,
	input  wire                      dbg_psel,
	input  wire                      dbg_penable,
	input  wire                      dbg_pwrite,
	input  wire [`TRAP_CSR_AW-1:0]   dbg_paddr,
	input  wire [`TRAP_XLEN-1:0]     dbg_pwdata,
	output logic [`TRAP_XLEN-1:0]    dbg_prdata,
	output logic                     dbg_pready,
	output logic                     s_psel,
	output logic                     s_penable,
	output logic                     s_pwrite,
	output logic [`TRAP_CSR_AW-1:0]  s_paddr,
	output logic [`TRAP_XLEN-1:0]    s_pwdata,
	input  wire [`TRAP_XLEN-1:0]     s_prdata,
	input  wire                      s_pready
);
	import trap_pkg::*;

	apb_owner_e owner_q;
	apb_owner_e grant;
	logic       in_access;
	logic       done;

	// owner registered means setup already went out, so this is the access phase
	assign in_access = (owner_q != OWNER_NONE);
	assign done      = s_psel & s_penable & s_pready;

	// idle: grant in the same cycle psel shows up, core first
	always_comb begin
		if (owner_q != OWNER_NONE)
			grant = owner_q;
		else if (core_psel)
			grant = OWNER_CORE;
		else if (dbg_psel)
			grant = OWNER_DBG;
		else
			grant = OWNER_NONE;
	end

	// completer side mux
	// penable is regenerated so a late winner still gets its own setup cycle
	always_comb begin
		s_psel    = 1'b0;
		s_penable = 1'b0;
		s_pwrite  = 1'b0;
		s_paddr   = '0;
		s_pwdata  = '0;
		case (grant)
			OWNER_CORE: begin
				s_psel    = core_psel;
				s_penable = core_penable & in_access;
				s_pwrite  = core_pwrite;
				s_paddr   = core_paddr;
				s_pwdata  = core_pwdata;
			end
			OWNER_DBG: begin
				s_psel    = dbg_psel;
				s_penable = dbg_penable & in_access;
				s_pwrite  = dbg_pwrite;
				s_paddr   = dbg_paddr;
				s_pwdata  = dbg_pwdata;
			end
			default: ;
		endcase
	end

	// responses only go back to the granted side
	// loser sees pready low and keeps waiting
	assign core_pready = (grant == OWNER_CORE) & s_pready;
	assign dbg_pready  = (grant == OWNER_DBG) & s_pready;
	assign core_prdata = (grant == OWNER_CORE) ? s_prdata : '0;
	assign dbg_prdata  = (grant == OWNER_DBG) ? s_prdata : '0;

	// release at the completing edge
	always_ff @(posedge clk) begin
		if (rst)
			owner_q <= OWNER_NONE;
		else if (done)
			owner_q <= OWNER_NONE;
		else
			owner_q <= grant;
	end

endmodule

`default_nettype wire

// ==== hdl/csr_file.sv ====
/*
 * machine CSR file with APB completer port
 * masked writes, fixed reserved fields, live mip
 * trap entry and mret updates of mstatus, mepc, mcause
 */
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module csr_file (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire [`TRAP_CSR_AW-1:0]    paddr,
	input  wire [`TRAP_XLEN-1:0]      pwdata,
	output logic [`TRAP_XLEN-1:0]     prdata,
	output logic                      pready,
	input  wire                       eip,
	input  wire                       tip,
	input  wire                       sip,
	input  wire                       exc_enter,
	input  wire                       exc_is_int,
	input  wire [`TRAP_XLEN-1:0]      exc_pc,
	input  wire [`TRAP_CAUSE_W-1:0]   exc_cause,
	input  wire                       exc_leave,
	input  wire [`TRAP_CAUSE_W-1:0]   irq_cause,
	output logic [`TRAP_XLEN-1:0]     mtvec_out,
	output logic [`TRAP_XLEN-1:0]     mepc_out,
	output logic                      mie_global,
	output logic                      meie,
	output logic                      mtie,
	output logic                      msie
);
	import trap_pkg::*;

	// writable fields
	// mstatus: MPP[12:11], MPIE[7], MIE[3]
	localparam logic [`TRAP_XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;
	// mie: MEIE, MTIE, MSIE
	localparam logic [`TRAP_XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
	// mtvec / mepc are word aligned
	localparam logic [`TRAP_XLEN-1:0] ALIGN_MASK    = 32'hFFFF_FFFC;
	localparam int                    CAUSE_PAD     = `TRAP_XLEN - 1 - `TRAP_CAUSE_W;

	logic [`TRAP_XLEN-1:0]    mstatus;
	logic [`TRAP_XLEN-1:0]    mie;
	logic [`TRAP_XLEN-1:0]    mtvec;
	logic [`TRAP_XLEN-1:0]    mscratch;
	logic [`TRAP_XLEN-1:0]    mepc;
	logic [`TRAP_XLEN-1:0]    mcause;
	logic [`TRAP_XLEN-1:0]    mtval;
	logic [`TRAP_XLEN-1:0]    mip_val;
	logic [`TRAP_CAUSE_W-1:0] trap_code;
	// 1 = machine, 0 = user
	logic                     mode;
	logic                     wr_en;

	// zero wait states, every access phase completes
	assign pready = psel & penable;
	assign wr_en  = pready & pwrite;

	// enables towards the interrupt controller
	assign mie_global = mstatus[3];
	assign meie       = mie[11];
	assign mtie       = mie[7];
	assign msie       = mie[3];

	// mip is just the pins, nothing stored
	always_comb begin
		mip_val     = '0;
		mip_val[11] = eip;
		mip_val[7]  = tip;
		mip_val[3]  = sip;
	end

	// interrupts take the controller's code
	assign trap_code = exc_is_int ? irq_cause : exc_cause;

	// read mux, unknown addresses read zero
	always_comb begin
		prdata = '0;
		case (paddr)
			CSR_MSTATUS:  prdata = mstatus;
			CSR_MISA:     prdata = `TRAP_MISA_VAL;
			CSR_MIE:      prdata = mie;
			CSR_MTVEC:    prdata = mtvec;
			CSR_MSCRATCH: prdata = mscratch;
			CSR_MEPC:     prdata = mepc;
			CSR_MCAUSE:   prdata = mcause;
			CSR_MTVAL:    prdata = mtval;
			CSR_MIP:      prdata = mip_val;
			default:      prdata = '0;
		endcase
	end

	// bus write beats trap entry, trap entry beats mret
	always_ff @(posedge clk) begin
		if (rst) begin
			mode     <= 1'b1;
			mstatus  <= `TRAP_MSTATUS_RST;
			mie      <= '0;
			mtvec    <= '0;
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtval    <= '0;
		end else if (wr_en) begin
			// misa and mip ignore writes
			case (paddr)
				CSR_MSTATUS:  mstatus  <= pwdata & MSTATUS_WMASK;
				CSR_MIE:      mie      <= pwdata & MIE_WMASK;
				CSR_MTVEC:    mtvec    <= pwdata & ALIGN_MASK;
				CSR_MSCRATCH: mscratch <= pwdata;
				CSR_MEPC:     mepc     <= pwdata & ALIGN_MASK;
				CSR_MCAUSE:   mcause   <= pwdata;
				CSR_MTVAL:    mtval    <= pwdata;
				default: ;
			endcase
		end else if (exc_enter) begin
			mepc        <= exc_pc & ALIGN_MASK;
			mcause      <= {exc_is_int, {CAUSE_PAD{1'b0}}, trap_code};
			// stack MIE into MPIE, remember previous mode
			mstatus[7]     <= mstatus[3];
			mstatus[3]     <= 1'b0;
			mstatus[12:11] <= {mode, mode};
			mode        <= 1'b1;
		end else if (exc_leave) begin
			// mret: pop MIE, MPP back to user
			mstatus[3]     <= mstatus[7];
			mstatus[7]     <= 1'b1;
			mstatus[12:11] <= 2'b00;
			mode        <= (mstatus[12:11] != 2'b00);
		end
	end

	// CPU copies, one cycle behind the CSRs
	always_ff @(posedge clk) begin
		mtvec_out <= mtvec;
		mepc_out  <= mepc;
	end

endmodule

`default_nettype wire

// ==== hdl/irq_controller.sv ====
/*
 * interrupt controller
 * pending detection, ext > timer > sw priority, cause code
 * interrupt level held until the CPU replies
 */
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module irq_controller (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       eip,
	input  wire                       tip,
	input  wire                       sip,
	input  wire                       mie_global,
	input  wire                       meie,
	input  wire                       mtie,
	input  wire                       msie,
	input  wire                       int_reply,
	output logic                      interrupt,
	output logic                      eip_reply,
	output logic [`TRAP_CAUSE_W-1:0]  irq_cause
);
	import trap_pkg::*;

	irq_state_e state;
	logic       ext_q;
	logic       tim_q;
	logic       pending_q;
	logic       reply_q;
	// {external, timer}, neither means software
	logic [1:0] src_q;

	// input stage
	// qualified sources and pending registered side by side
	always_ff @(posedge clk) begin
		if (rst) begin
			ext_q     <= 1'b0;
			tim_q     <= 1'b0;
			pending_q <= 1'b0;
			reply_q   <= 1'b0;
		end else begin
			ext_q     <= eip & meie;
			tim_q     <= tip & mtie;
			pending_q <= mie_global & ((eip & meie) | (tip & mtie) | (sip & msie));
			reply_q   <= int_reply;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			interrupt <= 1'b0;
			eip_reply <= 1'b0;
			src_q     <= 2'b00;
			irq_cause <= '0;
		end else begin
			case (state)
				IDLE: begin
					// latch the winner now, encode next cycle
					if (pending_q) begin
						src_q <= {ext_q, tim_q};
						state <= ISSUE;
					end
				end
				ISSUE: begin
					interrupt <= 1'b1;
					if (src_q[1]) begin
						// external also gets the reply pulse
						irq_cause <= 4'd11;
						eip_reply <= 1'b1;
					end else if (src_q[0]) begin
						irq_cause <= 4'd7;
					end else begin
						irq_cause <= 4'd3;
					end
					state <= WAIT_REPLY;
				end
				WAIT_REPLY: begin
					// single cycle pulse
					eip_reply <= 1'b0;
					if (reply_q) begin
						interrupt <= 1'b0;
						state     <= RETIRE;
					end
				end
				RETIRE: begin
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/trap_config.svh ====
/*
 * shared widths and constants for the machine-mode trap unit
 * data and CSR address widths, cause width, reset and misa values
 */
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// datapath and CSR bus widths
`define TRAP_XLEN 32
`define TRAP_CSR_AW 12

// MPP = 11, MPIE = 1 out of reset
`define TRAP_MSTATUS_RST 32'h0000_1880

// MXL = 01 (RV32), extensions I and M
`define TRAP_MISA_VAL 32'h4000_1100

// low field of mcause
`define TRAP_CAUSE_W 4

`endif

// ==== hdl/trap_pkg.sv ====
/*
 * trap unit types
 * CSR address map, interrupt FSM states, APB arbiter owners
 */
`default_nettype none

`include "trap_config.svh"

package trap_pkg;

	// machine CSR addresses
	typedef enum logic [`TRAP_CSR_AW-1:0] {
		CSR_MSTATUS  = 12'h300,
		CSR_MISA     = 12'h301,
		CSR_MIE      = 12'h304,
		CSR_MTVEC    = 12'h305,
		CSR_MSCRATCH = 12'h340,
		CSR_MEPC     = 12'h341,
		CSR_MCAUSE   = 12'h342,
		CSR_MTVAL    = 12'h343,
		CSR_MIP      = 12'h344
	} csr_addr_e;

	// interrupt request / reply FSM
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		ISSUE      = 2'd1,
		WAIT_REPLY = 2'd2,
		RETIRE     = 2'd3
	} irq_state_e;

	// who holds the shared CSR bus
	typedef enum logic [1:0] {
		OWNER_NONE = 2'd0,
		OWNER_CORE = 2'd1,
		OWNER_DBG  = 2'd2
	} apb_owner_e;

endpackage

`default_nettype wire

// ==== hdl/trap_unit_top.sv ====
/*
 * trap unit top
 * APB arbiter, machine CSR file, interrupt controller
 */
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_unit_top (
	input  wire                       clk,
	input  wire                       rst,
	// core CSR instruction port
	input  wire                       core_psel,
	input  wire                       core_penable,
	input  wire                       core_pwrite,
	input  wire [`TRAP_CSR_AW-1:0]    core_paddr,
	input  wire [`TRAP_XLEN-1:0]      core_pwdata,
	output wire [`TRAP_XLEN-1:0]      core_prdata,
	output wire                       core_pready,
	// debug host port
	input  wire                       dbg_psel,
	input  wire                       dbg_penable,
	input  wire                       dbg_pwrite,
	input  wire [`TRAP_CSR_AW-1:0]    dbg_paddr,
	input  wire [`TRAP_XLEN-1:0]      dbg_pwdata,
	output wire [`TRAP_XLEN-1:0]      dbg_prdata,
	output wire                       dbg_pready,
	// interrupt pins and CPU handshake
	input  wire                       eip,
	input  wire                       tip,
	input  wire                       sip,
	output wire                       eip_reply,
	output wire                       interrupt,
	input  wire                       int_reply,
	// trap interface
	input  wire                       exc_enter,
	input  wire                       exc_is_int,
	input  wire [`TRAP_XLEN-1:0]      exc_pc,
	input  wire [`TRAP_CAUSE_W-1:0]   exc_cause,
	input  wire                       exc_leave,
	output wire [`TRAP_XLEN-1:0]      mtvec_out,
	output wire [`TRAP_XLEN-1:0]      mepc_out
);

	// shared completer bus
	wire                      s_psel;
	wire                      s_penable;
	wire                      s_pwrite;
	wire [`TRAP_CSR_AW-1:0]   s_paddr;
	wire [`TRAP_XLEN-1:0]     s_pwdata;
	wire [`TRAP_XLEN-1:0]     s_prdata;
	wire                      s_pready;
	// enables and cause between CSRs and controller
	wire                      mie_global;
	wire                      meie;
	wire                      mtie;
	wire                      msie;
	wire [`TRAP_CAUSE_W-1:0]  irq_cause;

	apb_arbiter u_arbiter (
		.clk          (clk),
		.rst          (rst),
		.core_psel    (core_psel),
		.core_penable (core_penable),
		.core_pwrite  (core_pwrite),
		.core_paddr   (core_paddr),
		.core_pwdata  (core_pwdata),
		.core_prdata  (core_prdata),
		.core_pready  (core_pready),
		.dbg_psel     (dbg_psel),
		.dbg_penable  (dbg_penable),
		.dbg_pwrite   (dbg_pwrite),
		.dbg_paddr    (dbg_paddr),
		.dbg_pwdata   (dbg_pwdata),
		.dbg_prdata   (dbg_prdata),
		.dbg_pready   (dbg_pready),
		.s_psel       (s_psel),
		.s_penable    (s_penable),
		.s_pwrite     (s_pwrite),
		.s_paddr      (s_paddr),
		.s_pwdata     (s_pwdata),
		.s_prdata     (s_prdata),
		.s_pready     (s_pready)
	);

	csr_file u_csr (
		.clk        (clk),
		.rst        (rst),
		.psel       (s_psel),
		.penable    (s_penable),
		.pwrite     (s_pwrite),
		.paddr      (s_paddr),
		.pwdata     (s_pwdata),
		.prdata     (s_prdata),
		.pready     (s_pready),
		.eip        (eip),
		.tip        (tip),
		.sip        (sip),
		.exc_enter  (exc_enter),
		.exc_is_int (exc_is_int),
		.exc_pc     (exc_pc),
		.exc_cause  (exc_cause),
		.exc_leave  (exc_leave),
		.irq_cause  (irq_cause),
		.mtvec_out  (mtvec_out),
		.mepc_out   (mepc_out),
		.mie_global (mie_global),
		.meie       (meie),
		.mtie       (mtie),
		.msie       (msie)
	);

	irq_controller u_irq (
		.clk        (clk),
		.rst        (rst),
		.eip        (eip),
		.tip        (tip),
		.sip        (sip),
		.mie_global (mie_global),
		.meie       (meie),
		.mtie       (mtie),
		.msie       (msie),
		.int_reply  (int_reply),
		.interrupt  (interrupt),
		.eip_reply  (eip_reply),
		.irq_cause  (irq_cause)
	);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/trap_pkg.sv
hdl/apb_arbiter.sv
hdl/csr_file.sv
hdl/irq_controller.sv
hdl/trap_unit_top.sv
verification/trap_unit_props.sv
verification/trap_unit_tb.sv

// ==== verification/trap_unit_props.sv ====
/*
 * bound checks for the trap unit
 * pready only in access phases, setup before every completer access,
 * interrupt quiet after reset, single-cycle eip_reply, arbiter owner changes
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_props (
	input wire       clk,
	input wire       rst,
	input wire       core_psel,
	input wire       core_penable,
	input wire       core_pready,
	input wire       dbg_psel,
	input wire       dbg_penable,
	input wire       dbg_pready,
	input wire       s_psel,
	input wire       s_penable,
	input wire       s_pready,
	input wire       interrupt,
	input wire       eip_reply,
	input wire [1:0] owner
);
	import trap_pkg::*;

	wire done;

	// completing access on the shared port
	assign done = s_psel & s_penable & s_pready;

	// requesters only see pready in an access phase that follows their setup
	core_ready_in_access: assert property (@(posedge clk) disable iff (rst)
		core_pready |-> (core_psel && core_penable && $past(core_psel)))
		else $error("core_pready outside an access phase");

	dbg_ready_in_access: assert property (@(posedge clk) disable iff (rst)
		dbg_pready |-> (dbg_psel && dbg_penable && $past(dbg_psel)))
		else $error("dbg_pready outside an access phase");

	// shared port sees a setup cycle before every access
	completer_setup_first: assert property (@(posedge clk) disable iff (rst)
		s_pready |-> ($past(s_psel) && !$past(s_penable)))
		else $error("completer access phase without a setup cycle");

	// first two cycles out of reset
	quiet_first_cycle: assert property (@(posedge clk)
		($past(rst) && !rst) |-> !interrupt)
		else $error("interrupt high in the first cycle after reset");

	quiet_second_cycle: assert property (@(posedge clk)
		($past(rst, 2) && !$past(rst) && !rst) |-> !interrupt)
		else $error("interrupt high in the second cycle after reset");

	eip_reply_single: assert property (@(posedge clk) disable iff (rst)
		eip_reply |=> !eip_reply)
		else $error("eip_reply held longer than one cycle");

	// grant moves only from idle or at the completing edge
	owner_change: assert property (@(posedge clk) disable iff (rst)
		(owner != $past(owner)) |-> ($past(owner) == OWNER_NONE || $past(done)))
		else $error("arbiter owner changed in the middle of a transfer");

endmodule

bind trap_unit_top trap_unit_props u_props (
	.clk          (clk),
	.rst          (rst),
	.core_psel    (core_psel),
	.core_penable (core_penable),
	.core_pready  (core_pready),
	.dbg_psel     (dbg_psel),
	.dbg_penable  (dbg_penable),
	.dbg_pready   (dbg_pready),
	.s_psel       (s_psel),
	.s_penable    (s_penable),
	.s_pready     (s_pready),
	.interrupt    (interrupt),
	.eip_reply    (eip_reply),
	.owner        (u_arbiter.owner_q)
);

`default_nettype wire

// ==== verification/trap_unit_tb.sv ====
/*
 * trap unit testbench
 * clock, reset, APB master tasks for core and debug ports
 * directed tests for CSRs, arbitration, traps and interrupts
 * watchdog and closing summary
 */
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_unit_tb;
	import trap_pkg::*;

	localparam int CLK_NS      = 4;
	// about 250 cycles of directed traffic with a 20x margin
	localparam int TEST_CYCLES = 250;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 20;

	logic                     clk;
	logic                     rst;
	logic                     core_psel;
	logic                     core_penable;
	logic                     core_pwrite;
	logic [`TRAP_CSR_AW-1:0]  core_paddr;
	logic [`TRAP_XLEN-1:0]    core_pwdata;
	logic [`TRAP_XLEN-1:0]    core_prdata;
	logic                     core_pready;
	logic                     dbg_psel;
	logic                     dbg_penable;
	logic                     dbg_pwrite;
	logic [`TRAP_CSR_AW-1:0]  dbg_paddr;
	logic [`TRAP_XLEN-1:0]    dbg_pwdata;
	logic [`TRAP_XLEN-1:0]    dbg_prdata;
	logic                     dbg_pready;
	logic                     eip;
	logic                     tip;
	logic                     sip;
	logic                     eip_reply;
	logic                     interrupt;
	logic                     int_reply;
	logic                     exc_enter;
	logic                     exc_is_int;
	logic [`TRAP_XLEN-1:0]    exc_pc;
	logic [`TRAP_CAUSE_W-1:0] exc_cause;
	logic                     exc_leave;
	logic [`TRAP_XLEN-1:0]    mtvec_out;
	logic [`TRAP_XLEN-1:0]    mepc_out;

	// bookkeeping
	int                       err_count;
	int                       errs_at_start;
	int                       tests_run;
	int                       tests_failed;
	int                       core_done_t;
	int                       dbg_done_t;
	logic [`TRAP_XLEN-1:0]    mtval_shadow;

	trap_unit_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.core_psel    (core_psel),
		.core_penable (core_penable),
		.core_pwrite  (core_pwrite),
		.core_paddr   (core_paddr),
		.core_pwdata  (core_pwdata),
		.core_prdata  (core_prdata),
		.core_pready  (core_pready),
		.dbg_psel     (dbg_psel),
		.dbg_penable  (dbg_penable),
		.dbg_pwrite   (dbg_pwrite),
		.dbg_paddr    (dbg_paddr),
		.dbg_pwdata   (dbg_pwdata),
		.dbg_prdata   (dbg_prdata),
		.dbg_pready   (dbg_pready),
		.eip          (eip),
		.tip          (tip),
		.sip          (sip),
		.eip_reply    (eip_reply),
		.interrupt    (interrupt),
		.int_reply    (int_reply),
		.exc_enter    (exc_enter),
		.exc_is_int   (exc_is_int),
		.exc_pc       (exc_pc),
		.exc_cause    (exc_cause),
		.exc_leave    (exc_leave),
		.mtvec_out    (mtvec_out),
		.mepc_out     (mepc_out)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic complain(input string msg);
		$display("error at %0t: %s", $time, msg);
		err_count++;
	endtask

	task automatic open_test;
		errs_at_start = err_count;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (err_count != errs_at_start) begin
			tests_failed++;
			$display("[%0t] test %s: FAIL", $time, name);
		end else begin
			$display("[%0t] test %s: ok", $time, name);
		end
	endtask

	// setup then access until pready
	// pready sampled 1 ns into the low phase
	task automatic core_xfer(input logic wr, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge clk);
		core_psel    = 1'b1;
		core_penable = 1'b0;
		core_pwrite  = wr;
		core_paddr   = addr;
		core_pwdata  = wdata;
		@(negedge clk);
		core_penable = 1'b1;
		#1;
		while (!core_pready) begin
			@(negedge clk);
			#1;
		end
		rdata       = core_prdata;
		core_done_t = int'($time);
		// completing edge passes before this
		@(negedge clk);
		core_psel    = 1'b0;
		core_penable = 1'b0;
		core_pwrite  = 1'b0;
	endtask

	task automatic dbg_xfer(input logic wr, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge clk);
		dbg_psel    = 1'b1;
		dbg_penable = 1'b0;
		dbg_pwrite  = wr;
		dbg_paddr   = addr;
		dbg_pwdata  = wdata;
		@(negedge clk);
		dbg_penable = 1'b1;
		#1;
		// loser just sits here with pready low
		while (!dbg_pready) begin
			@(negedge clk);
			#1;
		end
		rdata      = dbg_prdata;
		dbg_done_t = int'($time);
		@(negedge clk);
		dbg_psel    = 1'b0;
		dbg_penable = 1'b0;
		dbg_pwrite  = 1'b0;
	endtask

	task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		core_xfer(1'b1, addr, data, unused_rd);
	endtask

	task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
		core_xfer(1'b0, addr, 32'h0, data);
	endtask

	// one-cycle trap entry pulse that returns after the CSR update edge
	task automatic pulse_enter(input logic is_int, input logic [31:0] pc,
			input logic [3:0] cause);
		@(negedge clk);
		exc_enter  = 1'b1;
		exc_is_int = is_int;
		exc_pc     = pc;
		exc_cause  = cause;
		@(negedge clk);
		exc_enter  = 1'b0;
		exc_is_int = 1'b0;
	endtask

	task automatic pulse_leave;
		@(negedge clk);
		exc_leave = 1'b1;
		@(negedge clk);
		exc_leave = 1'b0;
	endtask

	// counts falling edges until interrupt reaches level or passes limit
	task automatic wait_interrupt(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (interrupt !== level && cycles <= limit);
	endtask

	task automatic reply_interrupt;
		int n;
		int_reply = 1'b1;
		wait_interrupt(1'b0, 2, n);
		int_reply = 1'b0;
		if (n > 2)
			complain("interrupt still high 2 cycles after int_reply");
	endtask

	// value a CSR should hold after a write of w
	function automatic logic [31:0] after_write(input logic [11:0] addr, input logic [31:0] w);
		logic [31:0] v;
		v = '0;
		case (addr)
			CSR_MSTATUS: begin
				// MIE, MPIE, MPP
				v[3]     = w[3];
				v[7]     = w[7];
				v[12:11] = w[12:11];
			end
			CSR_MISA: v = `TRAP_MISA_VAL;
			CSR_MIE: begin
				v[3]  = w[3];
				v[7]  = w[7];
				v[11] = w[11];
			end
			CSR_MTVEC,
			CSR_MEPC: v = {w[31:2], 2'b00};
			default: v = w;
		endcase
		return v;
	endfunction

	task automatic reset_values;
		logic [11:0] zero_addrs [9];
		logic [31:0] rd;
		int          i;
		open_test();
		csr_read(CSR_MSTATUS, rd);
		check_word("mstatus after reset", rd, `TRAP_MSTATUS_RST);
		csr_read(CSR_MISA, rd);
		check_word("misa", rd, `TRAP_MISA_VAL);
		// the rest read zero and so do two unmapped addresses
		zero_addrs = '{CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
			CSR_MTVAL, CSR_MIP, 12'h302, 12'h7C0};
		for (i = 0; i < 9; i++) begin
			csr_read(zero_addrs[i], rd);
			check_word($sformatf("csr 0x%h after reset", zero_addrs[i]), rd, 32'h0);
		end
		close_test("reset_values");
	endtask

	task automatic masked_writes;
		logic [11:0] addrs [8];
		logic [31:0] w;
		logic [31:0] rd;
		int          i;
		open_test();
		addrs = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
			CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
		for (i = 0; i < 8; i++) begin
			w = $urandom;
			csr_write(addrs[i], w);
			if (addrs[i] == CSR_MTVEC) begin
				// mtvec_out trails the CSR by one edge
				@(negedge clk);
				check_word("mtvec_out", mtvec_out, {w[31:2], 2'b00});
			end
			if (addrs[i] == CSR_MTVAL)
				mtval_shadow = w;
			csr_read(addrs[i], rd);
			check_word($sformatf("csr 0x%h readback", addrs[i]), rd, after_write(addrs[i], w));
		end
		close_test("masked_writes");
	endtask

	task automatic arbitration;
		logic [31:0] core_w;
		logic [31:0] core_rd;
		logic [31:0] dbg_rd;
		open_test();
		core_w = $urandom;
		// same setup cycle on both ports
		fork
			core_xfer(1'b1, CSR_MSCRATCH, core_w, core_rd);
			dbg_xfer(1'b0, CSR_MTVAL, 32'h0, dbg_rd);
		join
		if (core_done_t >= dbg_done_t)
			complain("debug transfer finished before the core transfer");
		else if (dbg_done_t - core_done_t < 2 * CLK_NS)
			complain("debug transfer finished less than 2 cycles after the core");
		check_word("debug read of mtval", dbg_rd, mtval_shadow);
		dbg_xfer(1'b0, CSR_MSCRATCH, 32'h0, dbg_rd);
		check_word("mscratch written by core", dbg_rd, core_w);
		close_test("arbitration");
	endtask

	task automatic trap_entry_mret;
		logic [31:0] pc;
		logic [31:0] rd;
		logic [31:0] exp;
		open_test();
		// MIE set and MPP 00 while still in machine mode
		csr_write(CSR_MSTATUS, 32'h0000_0008);
		pc = $urandom;
		pulse_enter(1'b0, pc, 4'd2);
		@(negedge clk);
		check_word("mepc_out", mepc_out, {pc[31:2], 2'b00});
		csr_read(CSR_MCAUSE, rd);
		check_word("mcause after exception", rd, 32'h0000_0002);
		// MIE 0, MPIE 1, MPP 11
		exp       = '0;
		exp[7]    = 1'b1;
		exp[12:11] = 2'b11;
		csr_read(CSR_MSTATUS, rd);
		check_word("mstatus after trap entry", rd, exp);
		pulse_leave();
		// MIE back from MPIE, MPIE set, MPP 00
		exp    = '0;
		exp[3] = 1'b1;
		exp[7] = 1'b1;
		csr_read(CSR_MSTATUS, rd);
		check_word("mstatus after mret", rd, exp);
		close_test("trap_entry_mret");
	endtask

	task automatic irq_priority;
		logic [31:0] rd;
		int          n;
		open_test();
		csr_write(CSR_MIE, 32'h0000_0888);
		csr_write(CSR_MSTATUS, 32'h0000_1888);
		@(negedge clk);
		eip = 1'b1;
		tip = 1'b1;
		wait_interrupt(1'b1, 3, n);
		if (n > 3)
			complain("interrupt did not rise within 3 cycles of eip and tip");
		if (eip_reply !== 1'b1)
			complain("eip_reply did not come with the external interrupt");
		@(negedge clk);
		if (eip_reply !== 1'b0)
			complain("eip_reply lasted more than one cycle");
		pulse_enter(1'b1, 32'h0000_1000, 4'd0);
		csr_read(CSR_MCAUSE, rd);
		check_word("mcause for external interrupt", rd, 32'h8000_000B);
		eip = 1'b0;
		reply_interrupt();
		// second round with the timer alone
		// mret brings MIE back
		pulse_leave();
		wait_interrupt(1'b1, 3, n);
		if (n > 3)
			complain("timer interrupt did not rise within 3 cycles of MIE");
		if (eip_reply !== 1'b0)
			complain("eip_reply pulsed for a timer interrupt");
		pulse_enter(1'b1, 32'h0000_2000, 4'd0);
		csr_read(CSR_MCAUSE, rd);
		check_word("mcause for timer interrupt", rd, 32'h8000_0007);
		reply_interrupt();
		tip = 1'b0;
		close_test("irq_priority");
	endtask

	task automatic mip_pins;
		logic [31:0] rd;
		logic        quiet;
		int          i;
		open_test();
		csr_write(CSR_MSTATUS, 32'h0);
		sip = 1'b1;
		tip = 1'b1;
		csr_read(CSR_MIP, rd);
		// MSIP bit 3, MTIP bit 7
		check_word("mip with sip and tip", rd, 32'h0000_0088);
		quiet = 1'b1;
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			if (interrupt !== 1'b0)
				quiet = 1'b0;
		end
		if (!quiet)
			complain("interrupt raised while mstatus.MIE is clear");
		sip = 1'b0;
		tip = 1'b0;
		close_test("mip_pins");
	endtask

	// hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still busy after %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(5743));
		err_count     = 0;
		errs_at_start = 0;
		tests_run     = 0;
		tests_failed  = 0;
		core_done_t   = 0;
		dbg_done_t    = 0;
		mtval_shadow  = '0;
		clk           = 1'b0;
		rst           = 1'b1;
		core_psel     = 1'b0;
		core_penable  = 1'b0;
		core_pwrite   = 1'b0;
		core_paddr    = '0;
		core_pwdata   = '0;
		dbg_psel      = 1'b0;
		dbg_penable   = 1'b0;
		dbg_pwrite    = 1'b0;
		dbg_paddr     = '0;
		dbg_pwdata    = '0;
		eip           = 1'b0;
		tip           = 1'b0;
		sip           = 1'b0;
		int_reply     = 1'b0;
		exc_enter     = 1'b0;
		exc_is_int    = 1'b0;
		exc_pc        = '0;
		exc_cause     = '0;
		exc_leave     = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_values();
		masked_writes();
		arbitration();
		trap_entry_mret();
		irq_priority();
		mip_pins();
		$display("summary: %0d tests run, %0d failing, %0d errors", tests_run, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
